// File: gpio_subsystem.f
hw/apb_pkg.sv
hw/gpio_pkg.sv
hw/gpio_input_sync.sv
hw/apb_gpio.sv
hw/apb_bank_router.sv
hw/gpio_subsystem.sv
bench/gpio_subsystem_tb.sv

// File: bench/gpio_subsystem_vectors.txt
// op bank offset data expected expected_pslverr, all hex
// op 0 read, 1 write, 2 pin set, 3 port check, f end
// Reset values, out_init 0 and tris_init ffff
0 0 0 00000000 00000000 0
0 0 8 00000000 0000ffff 0
0 1 0 00000000 00000000 0
0 1 8 00000000 0000ffff 0
3 0 0 00000000 00000000 0
3 0 8 00000000 0000ffff 0
3 1 0 00000000 00000000 0
3 1 8 00000000 0000ffff 0
// Writes and readback, upper half reads zero
1 0 0 a5a5c3c3 00000000 0
0 0 0 00000000 0000c3c3 0
3 0 0 00000000 0000c3c3 0
3 1 0 00000000 00000000 0
1 0 8 ffff0f0f 00000000 0
0 0 8 00000000 00000f0f 0
3 0 8 00000000 00000f0f 0
3 1 8 00000000 0000ffff 0
// Pin readback through the synchronizer
2 0 4 00001234 00000000 0
0 0 4 00000000 00001234 0
2 1 4 0000beef 00000000 0
0 1 4 00000000 0000beef 0
0 0 4 00000000 00001234 0
// Register errors
1 0 4 ffffffff 00000000 1
0 0 4 00000000 00001234 0
0 0 c 00000000 00000000 1
1 0 c 12345678 00000000 1
0 0 0 00000000 0000c3c3 0
0 0 8 00000000 00000f0f 0
// Unmapped bank 5
0 5 0 00000000 00000000 1
1 5 0 ffffffff 00000000 1
1 5 8 ffffffff 00000000 1
0 0 0 00000000 0000c3c3 0
0 1 0 00000000 00000000 0
0 1 8 00000000 0000ffff 0
// Interleaved writes, banks stay independent
1 1 0 00005a5a 00000000 0
1 0 0 00000001 00000000 0
1 1 8 00000000 00000000 0
1 0 8 00008000 00000000 0
0 1 0 00000000 00005a5a 0
0 0 0 00000000 00000001 0
0 1 8 00000000 00000000 0
0 0 8 00000000 00008000 0
3 0 0 00000000 00000001 0
3 1 0 00000000 00005a5a 0
3 0 8 00000000 00008000 0
3 1 8 00000000 00000000 0
f 0 0 00000000 00000000 0

// File: bench/gpio_subsystem_tb.sv
module gpio_subsystem_tb;

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////
	// Configuration

	localparam int num_banks   = 2;
	localparam int gpio_width  = 16;
	localparam int max_vectors = 64;
	// op, bank, offset, data, expected value, expected pslverr
	localparam int fields      = 6;

	// Vector op codes
	localparam logic [31:0] op_read  = 32'h0;
	localparam logic [31:0] op_write = 32'h1;
	localparam logic [31:0] op_pins  = 32'h2;
	localparam logic [31:0] op_port  = 32'h3;
	localparam logic [31:0] op_end   = 32'hf;

	////////////////////
	// DUT signals

	logic                                 apb;
	logic                                 reset;
	logic                                 psel;
	logic                                 penable;
	logic                                 pwrite;
	logic [apb_pkg::addr_width-1:0]       paddr;
	logic [apb_pkg::data_width-1:0]       pwdata;
	logic [apb_pkg::data_width-1:0]       prdata;
	logic                                 pready;
	logic                                 pslverr;
	logic [num_banks*gpio_width-1:0]      gpio_out;
	logic [num_banks*gpio_width-1:0]      gpio_tris;
	logic [num_banks*gpio_width-1:0]      gpio_in;

	// Vector storage, six words per line
	logic [31:0] vec_mem [0:max_vectors*fields-1];
	int          vec_count;
	int          vec_idx;
	bit          vectors_loaded;

	// Scoreboard
	int error_count;
	int check_count;

	gpio_subsystem #(
		.num_banks  (num_banks),
		.gpio_width (gpio_width),
		.out_init   ('0),
		.tris_init  ('1)
	) u_dut (
		.apb        (apb),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.gpio_out   (gpio_out),
		.gpio_tris  (gpio_tris),
		.gpio_in    (gpio_in)
	);

	// 40 ns period
	initial begin
		apb = 1'b0;
		forever #20 apb = ~apb;
	end

	////////////////////
	// Helpers

	// Compare and log one value
	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error: %s expected 0x%08h actual 0x%08h (vector %0d)",
				name, expected, actual, vec_idx);
		end
	endtask

	// Bank number above the register offset
	function automatic logic [apb_pkg::addr_width-1:0] bus_addr(input logic [31:0] bank,
			input logic [31:0] offset);
		logic [apb_pkg::addr_width-1:0] addr;
		addr = '0;
		addr[apb_pkg::bank_lsb +: apb_pkg::bank_bits] = bank[apb_pkg::bank_bits-1:0];
		addr[gpio_pkg::reg_offset_bits-1:0] = offset[gpio_pkg::reg_offset_bits-1:0];
		return addr;
	endfunction

	// Setup then access, response sampled mid cycle
	task automatic apb_transfer(input logic write, input logic [apb_pkg::addr_width-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int  waited;
		bit  done;
		waited = 0;
		done   = 1'b0;
		rdata  = '0;
		err    = 1'b0;
		@(posedge apb);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		// Setup cycle, response still idle
		@(negedge apb);
		check("pready", 32'h0, 32'(pready));
		check("pslverr", 32'h0, 32'(pslverr));
		check("prdata", 32'h0, prdata);
		@(posedge apb);
		#2;
		penable = 1'b1;
		// Zero wait states, pready due in the first access cycle
		@(negedge apb);
		check("pready", 32'h1, 32'(pready));
		// Wait for pready, bounded
		while (pready !== 1'b1 && waited < 8) begin
			@(negedge apb);
			waited++;
		end
		if (pready === 1'b1) begin
			rdata = prdata;
			err   = pslverr;
			done  = 1'b1;
		end
		@(posedge apb);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		if (!done) begin
			error_count++;
			$display("Transfer of vector %0d got no pready within 8 cycles", vec_idx);
		end
	endtask

	// Drive one bank's pins, then let the synchronizer settle
	task automatic set_pins(input logic [31:0] bank, input logic [31:0] value);
		@(posedge apb);
		#2;
		gpio_in[bank*gpio_width +: gpio_width] = value[gpio_width-1:0];
		repeat (2) @(posedge apb);
	endtask

	// Port value of one bank, sampled away from the edge
	task automatic check_port(input logic [31:0] bank, input logic [31:0] offset,
			input logic [31:0] expected);
		logic [31:0] value;
		@(negedge apb);
		if (offset[3:0] == gpio_pkg::reg_gpio_out) begin
			value = 32'(gpio_out[bank*gpio_width +: gpio_width]);
			check($sformatf("gpio_out[bank %0d]", bank), expected, value);
		end else begin
			value = 32'(gpio_tris[bank*gpio_width +: gpio_width]);
			check($sformatf("gpio_tris[bank %0d]", bank), expected, value);
		end
	endtask

	// Sync reset, 16 cycles
	task automatic apply_reset();
		reset = 1'b1;
		repeat (16) @(posedge apb);
		#2;
		reset = 1'b0;
	endtask

	////////////////////
	// Vector loop

	task automatic run_vectors();
		logic [31:0] op;
		logic [31:0] bank;
		logic [31:0] offset;
		logic [31:0] data;
		logic [31:0] expected;
		logic [31:0] exp_err;
		logic [31:0] rdata;
		logic        err;
		int          idle;
		for (vec_idx = 0; vec_idx < vec_count; vec_idx++) begin
			op       = vec_mem[vec_idx*fields + 0];
			bank     = vec_mem[vec_idx*fields + 1];
			offset   = vec_mem[vec_idx*fields + 2];
			data     = vec_mem[vec_idx*fields + 3];
			expected = vec_mem[vec_idx*fields + 4];
			exp_err  = vec_mem[vec_idx*fields + 5];
			// Random gap between transactions
			idle = $urandom % 4;
			repeat (idle) @(posedge apb);
			case (op)
				op_read, op_write: begin
					apb_transfer(op == op_write, bus_addr(bank, offset), data, rdata, err);
					check("prdata", expected, rdata);
					check("pslverr", exp_err, 32'(err));
				end
				op_pins: set_pins(bank, data);
				op_port: check_port(bank, offset, expected);
				default: begin
					error_count++;
					$display("Vector %0d has an unknown operation code %0h", vec_idx, op);
				end
			endcase
		end
	endtask

	////////////////////
	// Watchdog

	initial begin
		wait (vectors_loaded);
		repeat (vec_count * 8 + 32) @(posedge apb);
		$display("Run timed out after %0d cycles before the last vector finished",
			vec_count * 8 + 32);
		$display("Regression failed");
		$finish;
	end

	////////////////////
	// Main sequence

	initial begin
		int unsigned seed;
		// Quiet bus, pins low
		reset          = 1'b1;
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		paddr          = '0;
		pwdata         = '0;
		gpio_in        = '0;
		error_count    = 0;
		check_count    = 0;
		vec_count      = 0;
		vec_idx        = 0;
		vectors_loaded = 1'b0;
		seed           = $urandom(32'h83bd);

		$readmemh("bench/gpio_subsystem_vectors.txt", vec_mem);
		// Count up to the end marker
		while (vec_count < max_vectors && vec_mem[vec_count*fields] !== op_end
				&& vec_mem[vec_count*fields] !== 32'hx) begin
			vec_count++;
		end

		if (vec_count == 0) begin
			$display("Vector file is missing or holds no vectors");
			$display("Regression failed");
		end else begin
			vectors_loaded = 1'b1;
			apply_reset();
			run_vectors();
			repeat (2) @(posedge apb);
			$display("Vectors: %0d  checks: %0d  errors: %0d", vec_count, check_count,
				error_count);
			if (error_count == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
		end
		$finish;
	end

endmodule

// File: hw/gpio_subsystem.sv
module gpio_subsystem #(
	parameter int                    num_banks  = 2,
	parameter int                    gpio_width = 16,
	parameter logic [gpio_width-1:0] out_init   = '0,
	parameter logic [gpio_width-1:0] tris_init  = '0
) (
	input  logic                             apb,
	input  logic                             reset,

	// APB requester side
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [apb_pkg::addr_width-1:0]   paddr,
	input  logic [apb_pkg::data_width-1:0]   pwdata,
	output logic [apb_pkg::data_width-1:0]   prdata,
	output logic                             pready,
	output logic                             pslverr,

	// Pins, bank 0 in the low bits
	output logic [num_banks*gpio_width-1:0]  gpio_out,
	output logic [num_banks*gpio_width-1:0]  gpio_tris,
	input  logic [num_banks*gpio_width-1:0]  gpio_in
);

	////////////////////
	// Parameter checks

	// Bank field limits the bank count
	if (num_banks < 1 || num_banks > 2**apb_pkg::bank_bits) begin : g_bad_banks
		$error("gpio_subsystem: num_banks out of range");
	end

	////////////////////
	// Internal wires

	logic [num_banks-1:0]                     bank_psel;
	logic [num_banks*apb_pkg::data_width-1:0] bank_prdata;
	logic [num_banks-1:0]                     bank_pready;
	logic [num_banks-1:0]                     bank_pslverr;
	// Pins after the synchronizers
	logic [num_banks*gpio_width-1:0]          gpio_sync;

	////////////////////
	// Bank router

	apb_bank_router #(
		.num_banks    (num_banks)
	) u_router (
		.apb          (apb),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.paddr        (paddr),
		.bank_psel    (bank_psel),
		.bank_prdata  (bank_prdata),
		.bank_pready  (bank_pready),
		.bank_pslverr (bank_pslverr),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	////////////////////
	// GPIO banks

	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		// Raw pins into the clock domain
		gpio_input_sync #(
			.gpio_width (gpio_width)
		) u_sync (
			.apb        (apb),
			.reset      (reset),
			.pins       (gpio_in[b*gpio_width +: gpio_width]),
			.sync       (gpio_sync[b*gpio_width +: gpio_width])
		);

		// Shares the bus, only psel is per bank
		apb_gpio #(
			.gpio_width (gpio_width),
			.out_init   (out_init),
			.tris_init  (tris_init)
		) u_gpio (
			.apb        (apb),
			.reset      (reset),
			.psel       (bank_psel[b]),
			.penable    (penable),
			.pwrite     (pwrite),
			.paddr      (paddr),
			.pwdata     (pwdata),
			.prdata     (bank_prdata[b*apb_pkg::data_width +: apb_pkg::data_width]),
			.pready     (bank_pready[b]),
			.pslverr    (bank_pslverr[b]),
			.gpio_out   (gpio_out[b*gpio_width +: gpio_width]),
			.gpio_tris  (gpio_tris[b*gpio_width +: gpio_width]),
			.gpio_in    (gpio_sync[b*gpio_width +: gpio_width])
		);
	end

endmodule

// File: hw/apb_bank_router.sv
module apb_bank_router #(
	parameter int num_banks = 2
) (
	// Used by the protocol checks only
	input  logic                                     apb,
	input  logic                                     reset,

	// Requester side
	input  logic                                     psel,
	input  logic                                     penable,
	input  logic [apb_pkg::addr_width-1:0]           paddr,

	// Bank side
	output logic [num_banks-1:0]                     bank_psel,
	input  logic [num_banks*apb_pkg::data_width-1:0] bank_prdata,
	input  logic [num_banks-1:0]                     bank_pready,
	input  logic [num_banks-1:0]                     bank_pslverr,

	// Response back to the requester
	output logic [apb_pkg::data_width-1:0]           prdata,
	output logic                                     pready,
	output logic                                     pslverr
);

	localparam int dw = apb_pkg::data_width;

	////////////////////
	// Bank decode

	// Bank number from paddr
	logic [apb_pkg::bank_bits-1:0] bank_sel;
	// Bank number has an instance behind it
	logic                          bank_mapped;

	assign bank_sel    = paddr[apb_pkg::bank_lsb +: apb_pkg::bank_bits];
	assign bank_mapped = int'(bank_sel) < num_banks;

	// One select per bank, none for an unmapped bank
	always_comb begin
		for (int i = 0; i < num_banks; i++) begin
			bank_psel[i] = psel && (int'(bank_sel) == i);
		end
	end

	////////////////////
	// Response mux

	always_comb begin
		prdata  = '0;
		pready  = 1'b0;
		pslverr = 1'b0;

		if (psel && !bank_mapped) begin
			// No bank there, answer with an error right away
			pready  = penable;
			pslverr = penable;
		end else begin
			// Forward whichever bank is selected
			for (int i = 0; i < num_banks; i++) begin
				if (bank_psel[i]) begin
					prdata  = bank_prdata[i*dw +: dw];
					pready  = bank_pready[i];
					pslverr = bank_pslverr[i];
				end
			end
		end
	end

	////////////////////
	// Protocol checks

	// At most one bank sees psel
	bank_psel_onehot: assert property (
		@(posedge apb) disable iff (reset)
		$onehot0(bank_psel)
	);

	// Access phase only inside a selected transfer
	penable_needs_psel: assert property (
		@(posedge apb) disable iff (reset)
		penable |-> psel
	);

	// Setup is followed by access on the same address
	setup_then_access: assert property (
		@(posedge apb) disable iff (reset)
		psel && !penable |=> psel && penable && $stable(paddr)
	);

endmodule

// File: hw/apb_gpio.sv
module apb_gpio #(
	parameter int                    gpio_width = 16,
	parameter logic [gpio_width-1:0] out_init   = '0,
	parameter logic [gpio_width-1:0] tris_init  = '0
) (
	input  logic                           apb,
	input  logic                           reset,

	// APB completer
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [apb_pkg::addr_width-1:0] paddr,
	input  logic [apb_pkg::data_width-1:0] pwdata,
	output logic [apb_pkg::data_width-1:0] prdata,
	output logic                           pready,
	output logic                           pslverr,

	// Pin side
	output logic [gpio_width-1:0]          gpio_out,
	output logic [gpio_width-1:0]          gpio_tris,
	input  logic [gpio_width-1:0]          gpio_in
);

	////////////////////
	// Parameter checks

	// Register alignment only works up to 32-bit APB
	if (apb_pkg::data_width > 32) begin : g_bad_bus
		$error("apb_gpio: data_width above 32 is not supported");
	end

	// Pins must fit in one bus word
	if (gpio_width > apb_pkg::data_width) begin : g_bad_width
		$error("apb_gpio: gpio_width wider than the data bus");
	end

	////////////////////
	// Address decode

	// Only the offset bits, the bank bits were handled upstream
	gpio_pkg::regid_t reg_id;

	assign reg_id = gpio_pkg::regid_t'(paddr[gpio_pkg::reg_offset_bits-1:0]);

	////////////////////
	// Read and response

	// Zero wait states, access cycle completes at once
	always_comb begin
		pready  = psel && penable;
		prdata  = '0;
		pslverr = 1'b0;

		if (pready) begin
			if (!pwrite) begin
				// Read, zero extended into the bus word
				case (reg_id)
					gpio_pkg::reg_gpio_out:  prdata[gpio_width-1:0] = gpio_out;
					gpio_pkg::reg_gpio_in:   prdata[gpio_width-1:0] = gpio_in;
					gpio_pkg::reg_gpio_tris: prdata[gpio_width-1:0] = gpio_tris;
					default:                 pslverr = 1'b1;
				endcase
			end else begin
				// Input register is read only
				if (reg_id != gpio_pkg::reg_gpio_out && reg_id != gpio_pkg::reg_gpio_tris) begin
					pslverr = 1'b1;
				end
			end
		end
	end

	////////////////////
	// Register writes

	// Update on the edge that ends the access cycle
	always_ff @(posedge apb) begin
		if (reset) begin
			gpio_out  <= out_init;
			gpio_tris <= tris_init;
		end else if (pready && pwrite) begin
			case (reg_id)
				gpio_pkg::reg_gpio_out:  gpio_out  <= pwdata[gpio_width-1:0];
				gpio_pkg::reg_gpio_tris: gpio_tris <= pwdata[gpio_width-1:0];
				// Errored writes change nothing
				default: ;
			endcase
		end
	end

	////////////////////
	// Checks

	// Never complete a transfer this bank was not selected for
	pready_needs_psel: assert property (
		@(posedge apb) disable iff (reset)
		pready |-> psel
	);

	// Error flag only on a completing cycle
	pslverr_needs_pready: assert property (
		@(posedge apb) disable iff (reset)
		pslverr |-> pready
	);

endmodule

// File: hw/gpio_input_sync.sv
module gpio_input_sync #(
	parameter int gpio_width = 16
) (
	input  logic                  apb,
	input  logic                  reset,
	input  logic [gpio_width-1:0] pins,
	output logic [gpio_width-1:0] sync
);

	////////////////////
	// Parameter checks

	// Pin vector has to fit in one bus word
	if (gpio_width < 1 || gpio_width > apb_pkg::data_width) begin : g_bad_width
		$error("gpio_input_sync: gpio_width out of range");
	end

	////////////////////
	// Synchronizer chain

	// First stage, may go metastable
	logic [gpio_width-1:0] meta;

	// Two flops per pin, no logic in between
	always_ff @(posedge apb) begin
		if (reset) begin
			meta <= '0;
			sync <= '0;
		end else begin
			// Capture raw pins
			meta <= pins;
			// Second stage settles
			sync <= meta;
		end
	end

endmodule

// File: hw/gpio_pkg.sv
////////////////////
// GPIO register map
////////////////////

package gpio_pkg;

	// Offset bits decoded inside one bank
	// Upper paddr bits go to the bank router
	localparam int reg_offset_bits = 4;

	////////////////////
	// Register IDs

	// Byte offsets of the bank registers
	typedef enum logic [reg_offset_bits-1:0] {
		// Output drive value, read/write
		reg_gpio_out  = 4'h0,
		// Synchronized pin state, read only
		reg_gpio_in   = 4'h4,
		// Tristate enable, read/write
		reg_gpio_tris = 4'h8
	} regid_t;

	// Offset 12 and everything else is undefined
	// Any access there completes with pslverr

endpackage

// File: hw/apb_pkg.sv
////////////////////
// APB bus geometry
////////////////////

package apb_pkg;

	// Address bus width
	// Covers the bank field plus the register offset inside a bank
	localparam int addr_width = 12;

	// Data bus width
	// Register map assumes 32-bit alignment, so never above 32
	localparam int data_width = 32;

	////////////////////
	// Bank field

	// Lowest paddr bit of the bank number
	// Bits below this one address a register inside the bank
	localparam int bank_lsb = 4;

	// Width of the bank number
	// Up to 16 banks can be decoded
	localparam int bank_bits = 4;

endpackage
